// ==== source/iir_filter_pkg.sv ====
package iir_filter_pkg;

	// Data path and gain formats
	localparam int sample_w = 15;
	localparam int gain_w = 25;
	localparam int frac_bits = 6;

	// Number of past states held in the delay line
	localparam int filter_order = 3;

	localparam int wb_addr_w = 3;
	localparam int wb_data_w = 32;

	// Register map, one word per gain
	typedef enum logic [wb_addr_w-1:0] {
		b0 = 3'd0,
		b1 = 3'd1,
		b2 = 3'd2,
		b3 = 3'd3,
		a1 = 3'd4,
		a2 = 3'd5,
		a3 = 3'd6
	} coef_index_e;

	// Gain k sits at bits [k*gain_w +: gain_w]
	localparam logic [(filter_order+1)*gain_w-1:0] default_num_gains = {
		gain_w'(662),
		gain_w'(-650),
		gain_w'(-221),
		gain_w'(216)
	};

	// a1 in the low slot
	localparam logic [filter_order*gain_w-1:0] default_den_gains = {
		gain_w'(-39),
		gain_w'(-316),
		gain_w'(28)
	};

	// Floor the product by frac_bits and keep the low sample bits
	function automatic logic signed [sample_w-1:0] scale_product(
		input logic signed [sample_w-1:0] sample,
		input logic signed [gain_w-1:0] gain
	);
		logic signed [sample_w+gain_w-1:0] product;
		product = sample * gain;
		return product[frac_bits +: sample_w];
	endfunction

endpackage

// ==== source/coefficient_regs.sv ====
`timescale 1ns/1ps

module coefficient_regs (
	input  logic clk,
	input  logic rst,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [iir_filter_pkg::wb_addr_w-1:0] wb_adr,
	input  logic [iir_filter_pkg::wb_data_w-1:0] wb_dat_i,
	output logic [iir_filter_pkg::wb_data_w-1:0] wb_dat_o,
	output logic wb_ack,
	output logic [(iir_filter_pkg::filter_order+1)*iir_filter_pkg::gain_w-1:0] num_gains,
	output logic [iir_filter_pkg::filter_order*iir_filter_pkg::gain_w-1:0] den_gains
);

	// b0..b3 then a1..a3, in register map order
	logic signed [iir_filter_pkg::gain_w-1:0] gains [2*iir_filter_pkg::filter_order+1];
	iir_filter_pkg::coef_index_e coef_sel;
	logic adr_valid;
	logic access;
	logic ack_q;

	assign coef_sel = iir_filter_pkg::coef_index_e'(wb_adr);
	assign adr_valid = (wb_adr <= iir_filter_pkg::a3);

	// New request only when no ack is pending
	assign access = wb_cyc && wb_stb && !ack_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign wb_ack = ack_q && wb_stb;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i <= iir_filter_pkg::filter_order; i++) begin
				gains[int'(iir_filter_pkg::b0) + i] <=
					iir_filter_pkg::default_num_gains[i*iir_filter_pkg::gain_w +: iir_filter_pkg::gain_w];
			end
			for (int i = 0; i < iir_filter_pkg::filter_order; i++) begin
				gains[int'(iir_filter_pkg::a1) + i] <=
					iir_filter_pkg::default_den_gains[i*iir_filter_pkg::gain_w +: iir_filter_pkg::gain_w];
			end
		end else if (access && wb_we && adr_valid) begin
			gains[coef_sel] <= wb_dat_i[iir_filter_pkg::gain_w-1:0];
		end
	end

	// Address is held until ack, so the read mux can stay combinational
	always_comb begin
		if (adr_valid) begin
			wb_dat_o = {
				{(iir_filter_pkg::wb_data_w-iir_filter_pkg::gain_w)
					{gains[coef_sel][iir_filter_pkg::gain_w-1]}},
				gains[coef_sel]
			};
		end else begin
			wb_dat_o = '0;
		end
	end

	for (genvar k = 0; k <= iir_filter_pkg::filter_order; k++) begin : g_num
		assign num_gains[k*iir_filter_pkg::gain_w +: iir_filter_pkg::gain_w] =
			gains[int'(iir_filter_pkg::b0) + k];
	end

	for (genvar k = 0; k < iir_filter_pkg::filter_order; k++) begin : g_den
		assign den_gains[k*iir_filter_pkg::gain_w +: iir_filter_pkg::gain_w] =
			gains[int'(iir_filter_pkg::a1) + k];
	end

endmodule

// ==== source/state_chain.sv ====
`timescale 1ns/1ps

module state_chain (
	input  logic clk,
	input  logic rst,
	input  logic signed [iir_filter_pkg::sample_w-1:0] data,
	input  logic data_en,
	input  logic signed [iir_filter_pkg::sample_w-1:0] den_sum,
	output logic signed [iir_filter_pkg::sample_w-1:0] state_now,
	output logic state_en,
	output logic [iir_filter_pkg::filter_order*iir_filter_pkg::sample_w-1:0] past_states
);

	logic signed [iir_filter_pkg::sample_w-1:0] error;

	// w[n] = x[n] - feedback, wraps at the sample width
	assign error = data - den_sum;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_now <= '0;
			state_en <= 1'b0;
		end else begin
			state_en <= data_en;
			if (data_en) begin
				state_now <= error;
			end
		end
	end

	// Delay line, w[n-1] in the low slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			past_states <= '0;
		end else if (state_en) begin
			past_states <= {
				past_states[(iir_filter_pkg::filter_order-1)*iir_filter_pkg::sample_w-1:0],
				state_now
			};
		end
	end

endmodule

// ==== source/denominator_feedback.sv ====
`timescale 1ns/1ps

module denominator_feedback (
	input  logic clk,
	input  logic rst,
	input  logic [iir_filter_pkg::filter_order*iir_filter_pkg::sample_w-1:0] past_states,
	input  logic [iir_filter_pkg::filter_order*iir_filter_pkg::gain_w-1:0] den_gains,
	output logic signed [iir_filter_pkg::sample_w-1:0] den_sum
);

	logic signed [iir_filter_pkg::sample_w-1:0] prod_q [iir_filter_pkg::filter_order];
	logic signed [iir_filter_pkg::sample_w-1:0] sum_next;

	// a_k applied to w[n-k], recomputed every cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int k = 0; k < iir_filter_pkg::filter_order; k++) begin
				prod_q[k] <= '0;
			end
		end else begin
			for (int k = 0; k < iir_filter_pkg::filter_order; k++) begin
				prod_q[k] <= iir_filter_pkg::scale_product(
					past_states[k*iir_filter_pkg::sample_w +: iir_filter_pkg::sample_w],
					den_gains[k*iir_filter_pkg::gain_w +: iir_filter_pkg::gain_w]);
			end
		end
	end

	always_comb begin
		sum_next = '0;
		for (int k = 0; k < iir_filter_pkg::filter_order; k++) begin
			sum_next = sum_next + prod_q[k];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			den_sum <= '0;
		end else begin
			den_sum <= sum_next;
		end
	end

endmodule

// ==== source/numerator_feedforward.sv ====
`timescale 1ns/1ps

module numerator_feedforward (
	input  logic clk,
	input  logic rst,
	input  logic signed [iir_filter_pkg::sample_w-1:0] state_now,
	input  logic state_en,
	input  logic [iir_filter_pkg::filter_order*iir_filter_pkg::sample_w-1:0] past_states,
	input  logic [(iir_filter_pkg::filter_order+1)*iir_filter_pkg::gain_w-1:0] num_gains,
	output logic signed [iir_filter_pkg::sample_w-1:0] data_out,
	output logic data_out_en
);

	logic signed [iir_filter_pkg::sample_w-1:0] prod_q [iir_filter_pkg::filter_order+1];
	logic prod_en;
	logic signed [iir_filter_pkg::sample_w-1:0] sum_next;

	// Past states are taken here before the delay line shifts
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			prod_en <= 1'b0;
			for (int k = 0; k <= iir_filter_pkg::filter_order; k++) begin
				prod_q[k] <= '0;
			end
		end else begin
			prod_en <= state_en;
			if (state_en) begin
				prod_q[0] <= iir_filter_pkg::scale_product(state_now,
					num_gains[0 +: iir_filter_pkg::gain_w]);
				for (int k = 1; k <= iir_filter_pkg::filter_order; k++) begin
					prod_q[k] <= iir_filter_pkg::scale_product(
						past_states[(k-1)*iir_filter_pkg::sample_w +: iir_filter_pkg::sample_w],
						num_gains[k*iir_filter_pkg::gain_w +: iir_filter_pkg::gain_w]);
				end
			end
		end
	end

	always_comb begin
		sum_next = '0;
		for (int k = 0; k <= iir_filter_pkg::filter_order; k++) begin
			sum_next = sum_next + prod_q[k];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_out <= '0;
			data_out_en <= 1'b0;
		end else begin
			data_out_en <= prod_en;
			if (prod_en) begin
				data_out <= sum_next;
			end
		end
	end

endmodule

// ==== source/iir_filter.sv ====
`timescale 1ns/1ps

module iir_filter (
	input  logic clk,
	input  logic rst,
	input  logic signed [iir_filter_pkg::sample_w-1:0] data,
	input  logic data_en,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [iir_filter_pkg::wb_addr_w-1:0] wb_adr,
	input  logic [iir_filter_pkg::wb_data_w-1:0] wb_dat_i,
	output logic [iir_filter_pkg::wb_data_w-1:0] wb_dat_o,
	output logic wb_ack,
	output logic signed [iir_filter_pkg::sample_w-1:0] data_out,
	output logic data_out_en
);

	logic [(iir_filter_pkg::filter_order+1)*iir_filter_pkg::gain_w-1:0] num_gains;
	logic [iir_filter_pkg::filter_order*iir_filter_pkg::gain_w-1:0] den_gains;
	logic signed [iir_filter_pkg::sample_w-1:0] state_now;
	logic state_en;
	logic [iir_filter_pkg::filter_order*iir_filter_pkg::sample_w-1:0] past_states;
	logic signed [iir_filter_pkg::sample_w-1:0] den_sum;

	coefficient_regs i_coefficient_regs (
		.clk       (clk),
		.rst       (rst),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack    (wb_ack),
		.num_gains (num_gains),
		.den_gains (den_gains)
	);

	// Error subtractor and delay line
	state_chain i_state_chain (
		.clk         (clk),
		.rst         (rst),
		.data        (data),
		.data_en     (data_en),
		.den_sum     (den_sum),
		.state_now   (state_now),
		.state_en    (state_en),
		.past_states (past_states)
	);

	denominator_feedback i_denominator_feedback (
		.clk         (clk),
		.rst         (rst),
		.past_states (past_states),
		.den_gains   (den_gains),
		.den_sum     (den_sum)
	);

	numerator_feedforward i_numerator_feedforward (
		.clk         (clk),
		.rst         (rst),
		.state_now   (state_now),
		.state_en    (state_en),
		.past_states (past_states),
		.num_gains   (num_gains),
		.data_out    (data_out),
		.data_out_en (data_out_en)
	);

endmodule

// ==== testbench/iir_filter_sva.sv ====
`timescale 1ns/1ps

module iir_filter_sva (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic data_en,
	input logic data_out_en
);

	int failures = 0;

	// Ack lasts one cycle
	ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack stayed high for two cycles");
			failures++;
		end

	ack_after_request: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> ($past(wb_cyc && wb_stb) && wb_cyc && wb_stb))
		else begin
			$error("wb_ack without a pending cyc and stb request");
			failures++;
		end

	// Fixed three cycle latency through the filter
	out_after_in: assert property (@(posedge clk) disable iff (rst)
		data_en |-> ##3 data_out_en)
		else begin
			$error("data_out_en missing three cycles after data_en");
			failures++;
		end

	out_from_in: assert property (@(posedge clk) disable iff (rst)
		data_out_en |-> $past(data_en, 3))
		else begin
			$error("data_out_en without data_en three cycles before");
			failures++;
		end

endmodule

bind iir_filter iir_filter_sva i_iir_filter_sva (
	.clk         (clk),
	.rst         (rst),
	.wb_cyc      (wb_cyc),
	.wb_stb      (wb_stb),
	.wb_ack      (wb_ack),
	.data_en     (data_en),
	.data_out_en (data_out_en)
);

// ==== testbench/iir_filter_tb.sv ====
`timescale 1ns/1ps

module iir_filter_tb;

	localparam int max_records = 64;

	logic clk;
	logic rst;
	logic signed [iir_filter_pkg::sample_w-1:0] data;
	logic data_en;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [iir_filter_pkg::wb_addr_w-1:0] wb_adr;
	logic [iir_filter_pkg::wb_data_w-1:0] wb_dat_i;
	logic [iir_filter_pkg::wb_data_w-1:0] wb_dat_o;
	logic wb_ack;
	logic signed [iir_filter_pkg::sample_w-1:0] data_out;
	logic data_out_en;

	// Four words per record: kind, address, data, expected
	logic [31:0] stim [0:4*max_records-1];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;

	iir_filter i_iir_filter (
		.clk         (clk),
		.rst         (rst),
		.data        (data),
		.data_en     (data_en),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.data_out    (data_out),
		.data_out_en (data_out_en)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the stimulus did not complete", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// One classic cycle held through the edge that samples ack, then an idle cycle
	task automatic wb_transfer(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr[iir_filter_pkg::wb_addr_w-1:0];
		wb_dat_i = wdata;
		@(posedge clk);
		#1;
		while (!wb_ack) begin
			@(posedge clk);
			#1;
		end
		rdata = wb_dat_o;
		// Master sees ack on this edge and ends the cycle
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic send_sample(input logic [31:0] x, input logic [31:0] exp);
		int latency;
		data = x[iir_filter_pkg::sample_w-1:0];
		data_en = 1'b1;
		@(posedge clk);
		#1;
		data_en = 1'b0;
		// The edge that sampled data_en counts as the first cycle
		latency = 1;
		while (!data_out_en) begin
			@(posedge clk);
			#1;
			latency++;
		end
		compare("data_out", {17'd0, data_out}, exp);
		compare("output latency", 32'(latency), 32'd3);
		// Next sample lands six cycles after this one
		repeat (3) begin
			@(posedge clk);
			#1;
		end
	endtask

	initial begin
		int records;
		int sva_failures;
		logic [31:0] kind;
		logic [31:0] rdata;
		clk = 1'b0;
		rst = 1'b1;
		data = '0;
		data_en = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		$readmemh("testbench/iir_filter_stim.txt", stim);
		records = 0;
		while (records < max_records && stim[4*records] < 32'd3) begin
			records++;
		end
		if (records == 0) begin
			$display("The stimulus file held no usable records");
			errors++;
		end
		cycle_limit = records * 12 + 100;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int r = 0; r < records; r++) begin
			kind = stim[4*r];
			case (kind)
				32'd0: wb_transfer(1'b1, stim[4*r+1], stim[4*r+2], rdata);
				32'd1: begin
					wb_transfer(1'b0, stim[4*r+1], 32'd0, rdata);
					compare($sformatf("read of address %0d", stim[4*r+1]), rdata, stim[4*r+3]);
				end
				32'd2: send_sample(stim[4*r+2], stim[4*r+3]);
				default: begin
					$display("Record %0d has an unknown kind %0h", r, kind);
					errors++;
				end
			endcase
		end
		sva_failures = i_iir_filter.i_iir_filter_sva.failures;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, sva_failures);
		if (errors == 0 && sva_failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== iir_filter.f ====
source/iir_filter_pkg.sv
source/coefficient_regs.sv
source/state_chain.sv
source/denominator_feedback.sv
source/numerator_feedforward.sv
source/iir_filter.sv
testbench/iir_filter_sva.sv
testbench/iir_filter_tb.sv

// ==== testbench/iir_filter_stim.txt ====
// kind addr data expected, in hex; kind 0 write, 1 read, 2 sample, 3 end of records
// Reads expect the 32-bit word, samples expect the 15-bit output
// Default gains after reset
1 0 00000000 000000D8
1 1 00000000 FFFFFF23
1 2 00000000 FFFFFD76
1 3 00000000 00000296
1 4 00000000 0000001C
1 5 00000000 FFFFFEC4
1 6 00000000 FFFFFFD9
1 7 00000000 00000000
// Impulse response with default gains
2 0 00000040 000000D8
2 0 00000000 00007EC4
2 0 00000000 0000022C
2 0 00000000 00007C10
2 0 00000000 00000BAB
// Pass-through gains, upper data bits dropped on b1
0 0 00000040 00000000
1 0 00000000 00000040
0 1 FE000000 00000000
1 1 00000000 00000000
0 2 00000000 00000000
1 2 00000000 00000000
0 3 00000000 00000000
1 3 00000000 00000000
0 4 00000000 00000000
1 4 00000000 00000000
0 5 00000000 00000000
1 5 00000000 00000000
0 6 00000000 00000000
1 6 00000000 00000000
2 0 00001234 00001234
2 0 00007ABC 00007ABC
2 0 00004000 00004000
// b0 = 2.0, b1 = -0.5, a1 = 1.0 with full-scale input
0 0 00000080 00000000
1 0 00000000 00000080
0 1 01FFFFE0 00000000
1 1 00000000 FFFFFFE0
0 4 00000040 00000000
1 4 00000000 00000040
2 0 00003FFF 00001FFE
2 0 00004000 00000002
2 0 00003FFF 00001FFB
2 0 00003FFF 00000003
2 0 00004000 00001FFD
3 0 00000000 00000000
